/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := tb_ahb2apb_bridge
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* ahb2apb_bridge.sv */
// AHB-Lite to APB bridge top

`timescale 1ns/10ps

module ahb2apb_bridge import bridge_pkg::*; (
  input  logic                  hclk15,
  input  logic                  hreset_n15,
  // AHB slave port
  input  logic                  hsel,
  input  addr_t                 haddr,
  input  htrans_t               htrans,
  input  logic                  hwrite,
  input  data_t                 hwdata,
  output data_t                 hrdata,
  output logic                  hready,
  // APB master port
  output addr_t                 paddr,
  output logic                  pwrite,
  output data_t                 pwdata,
  output logic                  penable,
  output slave_sel_t            psel,
  input  logic [NUM_SLAVES-1:0] pready,
  input  data_t                 prdata0,
  input  data_t                 prdata1,
  input  data_t                 prdata2,
  input  data_t                 prdata3
);

  logic       req;
  addr_t      cap_addr;
  logic       cap_write;
  slave_sel_t cap_sel;
  logic       xfer_done;
  logic       sel_ready;

  // ------------------------------------------------------------
  // Capture stage
  // ------------------------------------------------------------
  ahb_capture ahb_capture_inst (
    .hclk15     (hclk15),
    .hreset_n15 (hreset_n15),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .xfer_done  (xfer_done),
    .hready     (hready),
    .req        (req),
    .addr       (cap_addr),
    .write      (cap_write),
    .sel        (cap_sel),
    .wdata      (pwdata)
  );

  // ------------------------------------------------------------
  // APB sequencing
  // ------------------------------------------------------------
  apb_sequencer apb_sequencer_inst (
    .hclk15     (hclk15),
    .hreset_n15 (hreset_n15),
    .req        (req),
    .addr       (cap_addr),
    .write      (cap_write),
    .sel        (cap_sel),
    .sel_ready  (sel_ready),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .xfer_done  (xfer_done)
  );

  // ------------------------------------------------------------
  // Read return
  // ------------------------------------------------------------
  apb_read_return apb_read_return_inst (
    .hclk15     (hclk15),
    .hreset_n15 (hreset_n15),
    .psel       (psel),
    .pready     (pready),
    .prdata0    (prdata0),
    .prdata1    (prdata1),
    .prdata2    (prdata2),
    .prdata3    (prdata3),
    .xfer_done  (xfer_done),
    .sel_ready  (sel_ready),
    .hrdata     (hrdata)
  );

endmodule

/* ahb_capture.sv */
// AHB transfer capture

`timescale 1ns/10ps

module ahb_capture import bridge_pkg::*; (
  input  logic       hclk15,
  input  logic       hreset_n15,
  input  logic       hsel,
  input  addr_t      haddr,
  input  htrans_t    htrans,
  input  logic       hwrite,
  input  data_t      hwdata,
  input  logic       xfer_done,
  output logic       hready,
  output logic       req,
  output addr_t      addr,
  output logic       write,
  output slave_sel_t sel,
  output data_t      wdata
);

  logic                 valid_trans;
  logic                 accept;
  logic                 data_phase;
  logic [SEL_WIDTH-1:0] sel_idx;

  // ------------------------------------------------------------
  // Address phase decode
  // ------------------------------------------------------------
  // Only NONSEQ and SEQ start a transfer
  assign valid_trans = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
  assign accept      = hready && valid_trans;

  // Every address maps to a slave, so no miss case
  assign sel_idx = haddr[SEL_LSB +: SEL_WIDTH];

  // Handshake state
  always_ff @(posedge hclk15 or negedge hreset_n15) begin
    if (!hreset_n15) begin
      hready     <= 1'b1;
      req        <= 1'b0;
      data_phase <= 1'b0;
    end else begin
      data_phase <= accept;
      if (accept) begin
        hready <= 1'b0;
        req    <= 1'b1;
      end else if (xfer_done) begin
        hready <= 1'b1;
        req    <= 1'b0;
      end
    end
  end

  // Held steady while req is up
  always_ff @(posedge hclk15) begin
    if (accept) begin
      addr  <= haddr;
      write <= hwrite;
      sel   <= slave_sel_t'(1) << sel_idx;
    end
  end

  // ------------------------------------------------------------
  // Data phase
  // ------------------------------------------------------------
  // Write data arrives one cycle after acceptance
  always_ff @(posedge hclk15 or negedge hreset_n15) begin
    if (!hreset_n15) begin
      wdata <= '0;
    end else if (data_phase) begin
      wdata <= hwdata;
    end
  end

  // Completion only ends an outstanding transfer
  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    xfer_done |-> req);

endmodule

/* apb_read_return.sv */
// APB read data return

`timescale 1ns/10ps

module apb_read_return import bridge_pkg::*; (
  input  logic                  hclk15,
  input  logic                  hreset_n15,
  input  slave_sel_t            psel,
  input  logic [NUM_SLAVES-1:0] pready,
  input  data_t                 prdata0,
  input  data_t                 prdata1,
  input  data_t                 prdata2,
  input  data_t                 prdata3,
  input  logic                  xfer_done,
  output logic                  sel_ready,
  output data_t                 hrdata
);

  data_t prdata_arr [NUM_SLAVES];
  data_t rdata_sel;

  assign prdata_arr[0] = prdata0;
  assign prdata_arr[1] = prdata1;
  assign prdata_arr[2] = prdata2;
  assign prdata_arr[3] = prdata3;

  // pready of the selected slave only
  assign sel_ready = |(psel & pready);

  // AND-OR mux, psel is one-hot
  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      rdata_sel = rdata_sel | ({DATA_WIDTH{psel[i]}} & prdata_arr[i]);
    end
  end

  // ------------------------------------------------------------
  // Registered return to AHB
  // ------------------------------------------------------------
  always_ff @(posedge hclk15 or negedge hreset_n15) begin
    if (!hreset_n15) begin
      hrdata <= '0;
    end else if (xfer_done) begin
      hrdata <= rdata_sel;
    end
  end

endmodule

/* apb_sequencer.sv */
// APB transfer sequencer

`timescale 1ns/10ps

module apb_sequencer import bridge_pkg::*; (
  input  logic       hclk15,
  input  logic       hreset_n15,
  input  logic       req,
  input  addr_t      addr,
  input  logic       write,
  input  slave_sel_t sel,
  input  logic       sel_ready,
  output slave_sel_t psel,
  output logic       penable,
  output addr_t      paddr,
  output logic       pwrite,
  output logic       xfer_done
);

  apb_state_t state;

  // Last ACCESS cycle of the transfer
  assign xfer_done = (state == APB_ACCESS) && sel_ready;

  // ------------------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // ------------------------------------------------------------
  always_ff @(posedge hclk15 or negedge hreset_n15) begin
    if (!hreset_n15) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (req) begin
            state  <= APB_SETUP;
            psel   <= sel;
            paddr  <= addr;
            pwrite <= write;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end

        APB_ACCESS: begin
          // Wait states extend ACCESS until pready
          if (sel_ready) begin
            state   <= APB_IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    $onehot0(psel));

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    penable |-> (psel != '0));

  // Address, direction and select frozen until the access ends
  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    ((state == APB_SETUP) || ((state == APB_ACCESS) && !sel_ready))
      |=> ($stable(paddr) && $stable(pwrite) && $stable(psel)));

endmodule

/* bridge_pkg.sv */
// AHB to APB bridge definitions

package bridge_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int NUM_SLAVES = 4;

  // Slave index sits in haddr[13:12]
  localparam int SEL_LSB   = 12;
  localparam int SEL_WIDTH = 2;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [1:0]            htrans_t;

  // One-hot peripheral select
  typedef logic [NUM_SLAVES-1:0] slave_sel_t;

  // ------------------------------------------------------------
  // AHB transfer codes
  // ------------------------------------------------------------
  // IDLE and BUSY are ignored by the bridge
  localparam htrans_t HTRANS_NONSEQ = 2'd2;
  localparam htrans_t HTRANS_SEQ    = 2'd3;

  // ------------------------------------------------------------
  // APB sequencer states
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_t;

endpackage

/* tb.f */
bridge_pkg.sv
ahb_capture.sv
apb_sequencer.sv
apb_read_return.sv
ahb2apb_bridge.sv
tb_ahb2apb_bridge.sv

/* tb_ahb2apb_bridge.sv */
// AHB to APB bridge testbench

`timescale 1ns/10ps

module tb_ahb2apb_bridge import bridge_pkg::*; ();

  localparam int      CLK_PERIOD    = 100;
  localparam int      RESET_CYCLES  = 4;
  localparam int      NUM_XFERS     = 2 * NUM_SLAVES;
  localparam int      MARGIN_CYCLES = 40;
  localparam int      TIMEOUT_NS    =
    (NUM_XFERS * (3 + 3) + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
  localparam htrans_t HTRANS_IDLE   = 2'd0;
  localparam htrans_t HTRANS_BUSY   = 2'd1;

  logic                  hclk15;
  logic                  hreset_n15;
  logic                  hsel;
  addr_t                 haddr;
  htrans_t               htrans;
  logic                  hwrite;
  data_t                 hwdata;
  data_t                 hrdata;
  logic                  hready;
  addr_t                 paddr;
  logic                  pwrite;
  data_t                 pwdata;
  logic                  penable;
  slave_sel_t            psel;
  logic [NUM_SLAVES-1:0] pready;
  data_t                 prdata_m [NUM_SLAVES];

  // Accepted transfer as seen by the AHB driver
  addr_t       acc_haddr;
  logic        acc_hwrite;
  data_t       acc_hwdata;
  int          last_waits;
  int          errors;
  logic [31:0] stim_rng;
  logic [31:0] wait_rng;
  logic        acc_d1;
  logic        acc_d2;
  logic        acc_d3;

  ahb2apb_bridge ahb2apb_bridge_inst (
    .hclk15     (hclk15),
    .hreset_n15 (hreset_n15),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hrdata     (hrdata),
    .hready     (hready),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .penable    (penable),
    .psel       (psel),
    .pready     (pready),
    .prdata0    (prdata_m[0]),
    .prdata1    (prdata_m[1]),
    .prdata2    (prdata_m[2]),
    .prdata3    (prdata_m[3])
  );

  always begin
    hclk15 = 1'b0;
    #(CLK_PERIOD / 2);
    hclk15 = 1'b1;
    #(CLK_PERIOD / 2);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("Assertion failed: %s", what);
  endtask

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  // Registered acceptance delayed two more cycles lines up with penable rising
  always @(posedge hclk15 or negedge hreset_n15) begin
    if (!hreset_n15) begin
      acc_d1 <= 1'b0;
      acc_d2 <= 1'b0;
      acc_d3 <= 1'b0;
    end else begin
      acc_d1 <= hready && hsel && htrans[1];
      acc_d2 <= acc_d1;
      acc_d3 <= acc_d2;
    end
  end

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    (psel != '0) |-> ($onehot(psel) && psel[acc_haddr[SEL_LSB +: SEL_WIDTH]]))
    else note_failure("psel does not match the decoded address bits");

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    (psel != '0) |-> ((paddr == acc_haddr) && (pwrite == acc_hwrite)))
    else note_failure("paddr or pwrite differs from the accepted transfer");

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    ((psel != '0) && !(penable && |(psel & pready)))
      |=> ($stable(paddr) && $stable(pwrite) && $stable(psel)))
    else note_failure("APB address or control changed before completion");

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    acc_d3 == $rose(penable))
    else note_failure("penable did not rise two cycles after acceptance");

  assert property (@(posedge hclk15) disable iff (!hreset_n15)
    (hready && !(hsel && htrans[1])) |=> (hready && (psel == '0)))
    else note_failure("a non-transfer started an APB access");

  // ------------------------------------------------------------
  // APB slave models
  // ------------------------------------------------------------
  initial begin
    data_t mem [NUM_SLAVES][4];
    int    wait_left [NUM_SLAVES];
    pready     = '0;
    last_waits = 0;
    wait_rng   = 32'h9a9f76b7;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      prdata_m[s]  = '0;
      wait_left[s] = 0;
      for (int w = 0; w < 4; w++) begin
        mem[s][w] = 32'h5a00_0000 | (s << 8) | w;
      end
    end
    forever begin
      @(negedge hclk15);
      for (int s = 0; s < NUM_SLAVES; s++) begin
        pready[s]   = 1'b0;
        prdata_m[s] = '0;
        if (psel[s] && !penable) begin
          // SETUP picks the wait count for the coming ACCESS
          wait_rng     = xorshift32(wait_rng);
          wait_left[s] = int'(wait_rng[1:0]);
          last_waits   = wait_left[s];
        end else if (psel[s] && penable) begin
          if (wait_left[s] != 0) begin
            wait_left[s]--;
          end else begin
            pready[s] = 1'b1;
            if (pwrite) begin
              check_value($sformatf("pwdata slave %0d", s), acc_hwdata, pwdata);
              mem[s][paddr[3:2]] = pwdata;
            end
            prdata_m[s] = mem[s][paddr[3:2]];
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // AHB driver
  // ------------------------------------------------------------
  // Called on a falling edge with hready high
  task automatic ahb_transfer(input string name, input addr_t addr, input logic write,
                              input data_t wdata, output data_t rdata);
    int low_cycles;
    low_cycles = 0;
    acc_haddr  = addr;
    acc_hwrite = write;
    acc_hwdata = wdata;
    hsel       = 1'b1;
    haddr      = addr;
    htrans     = HTRANS_NONSEQ;
    hwrite     = write;
    hwdata     = wdata;
    @(negedge hclk15);
    while (!hready) begin
      low_cycles++;
      @(negedge hclk15);
    end
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    rdata  = hrdata;
    check_value({name, " latency"}, 3 + last_waits, low_cycles);
  endtask

  task automatic drive_non_transfer(input logic sel, input htrans_t trans);
    stim_rng = xorshift32(stim_rng);
    hsel     = sel;
    htrans   = trans;
    haddr    = stim_rng;
    hwrite   = 1'b1;
    repeat (4) @(negedge hclk15);
    check_value("non-transfer hready", 1, hready);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    addr_t addr;
    data_t data;
    data_t rdata;
    errors     = 0;
    stim_rng   = 32'h9a9f76b7;
    hreset_n15 = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = HTRANS_IDLE;
    hwrite     = 1'b0;
    hwdata     = '0;
    acc_haddr  = '0;
    acc_hwrite = 1'b0;
    acc_hwdata = '0;
    repeat (RESET_CYCLES) @(posedge hclk15);
    @(negedge hclk15);
    hreset_n15 = 1'b1;
    @(negedge hclk15);

    check_value("reset hready", 1, hready);
    check_value("reset psel", 0, psel);
    check_value("reset penable", 0, penable);
    check_value("reset pwrite", 0, pwrite);
    check_value("reset hrdata", 0, hrdata);
    check_value("reset paddr", 0, paddr);
    check_value("reset pwdata", 0, pwdata);

    // Write then read back, one address per slave
    for (int s = 0; s < NUM_SLAVES; s++) begin
      stim_rng                   = xorshift32(stim_rng);
      addr                       = stim_rng;
      addr[SEL_LSB +: SEL_WIDTH] = 2'(s);
      addr[1:0]                  = 2'b00;
      stim_rng                   = xorshift32(stim_rng);
      data                       = stim_rng;
      ahb_transfer($sformatf("write slave %0d", s), addr, 1'b1, data, rdata);
      ahb_transfer($sformatf("read slave %0d", s), addr, 1'b0, ~data, rdata);
      check_value($sformatf("readback slave %0d", s), data, rdata);
    end

    drive_non_transfer(1'b0, HTRANS_NONSEQ);
    drive_non_transfer(1'b1, HTRANS_IDLE);
    drive_non_transfer(1'b1, HTRANS_BUSY);

    repeat (2) @(negedge hclk15);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
